//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= axil_regs_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/axil_regs_checker.sv
`default_nettype none

module axil_regs_checker (
    input wire                        clk,
    input wire                        rst,
    input wire                        s_axil_rvalid,
    input wire                        s_axil_rready,
    input wire axil_regs_pkg::data_t  s_axil_rdata,
    input wire [1:0]                  s_axil_rresp,
    input wire                        s_axil_bvalid,
    input wire                        s_axil_bready,
    input wire [1:0]                  s_axil_bresp,
    input wire                        rd_en,
    input wire                        wr_en
);

    // count of failed properties for the testbench.
    int fail_count = 0;

    // R holds its beat until rready.
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
        else begin fail_count++; $error("rvalid or rdata changed before rready"); end

    // B holds until bready.
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else begin fail_count++; $error("bvalid dropped before bready"); end

    // always OKAY.
    resp_okay: assert property (@(posedge clk) disable iff (rst)
        (!s_axil_rvalid || s_axil_rresp == 2'b00) && (!s_axil_bvalid || s_axil_bresp == 2'b00))
        else begin fail_count++; $error("rresp or bresp not OKAY"); end

    // strobes quiet right after reset.
    en_after_reset: assert property (@(posedge clk) $fell(rst) |-> !rd_en && !wr_en)
        else begin fail_count++; $error("register strobe high after reset"); end

endmodule

`default_nettype wire

//--- testbench/axil_regs_tb.sv
`default_nettype none

`include "axil_regs_defs.svh"

module axil_regs_tb;

    // about 70 accesses at up to 15 cycles each with stalls, plus margin.
    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic rst;
    axil_regs_pkg::addr_t s_axil_araddr, s_axil_awaddr;
    logic [2:0] s_axil_arprot, s_axil_awprot;
    logic s_axil_arvalid, s_axil_arready, s_axil_rvalid, s_axil_rready;
    axil_regs_pkg::data_t s_axil_rdata, s_axil_wdata;
    logic [1:0] s_axil_rresp, s_axil_bresp;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    axil_regs_pkg::strb_t s_axil_wstrb;
    logic s_axil_bvalid, s_axil_bready;

    // words at 0x04 and 0x08.
    axil_regs_pkg::data_t model [1:2];
    // expected read data in issue order.
    axil_regs_pkg::data_t rd_expect [0:255];
    int rd_issued, rd_done, wr_issued, wr_done;
    int cycles = 0;
    logic stall_ready;

    axil_regs_top dut (.*);

    bind axil_regs_top axil_regs_checker u_check (
        .clk (clk), .rst (rst),
        .s_axil_rvalid (s_axil_rvalid), .s_axil_rready (s_axil_rready),
        .s_axil_rdata (s_axil_rdata), .s_axil_rresp (s_axil_rresp),
        .s_axil_bvalid (s_axil_bvalid), .s_axil_bready (s_axil_bready),
        .s_axil_bresp (s_axil_bresp),
        .rd_en (reg_bus.rd_en), .wr_en (reg_bus.wr_en)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input axil_regs_pkg::data_t got,
                               input axil_regs_pkg::data_t want);
        assert (got == want)
            else abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, want));
    endtask

    // id is constant, unmapped reads are zero.
    function automatic axil_regs_pkg::data_t expected_word(input axil_regs_pkg::addr_t addr);
        if (addr == `REG_ID_ADDR) return `REG_ID_VALUE;
        if (addr == `REG_SCRATCH_ADDR || addr == `REG_SLOW_ADDR) return model[addr[3:2]];
        return '0;
    endfunction

    // byte mask built from the strobes; id and unmapped writes are dropped.
    task automatic update_model(input axil_regs_pkg::addr_t addr,
                                input axil_regs_pkg::data_t data, input axil_regs_pkg::strb_t strb);
        axil_regs_pkg::data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if (addr == `REG_SCRATCH_ADDR || addr == `REG_SLOW_ADDR) begin
            model[addr[3:2]] = (model[addr[3:2]] & ~mask) | (data & mask);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic issue_read(input axil_regs_pkg::addr_t addr);
        s_axil_araddr = addr;
        s_axil_arvalid = 1'b1;
        rd_expect[rd_issued[7:0]] = expected_word(addr);
        rd_issued++;
        while (!s_axil_arready) @(negedge clk);
        @(negedge clk);
        s_axil_arvalid = 1'b0;
    endtask

    task automatic issue_write(input axil_regs_pkg::addr_t addr,
                               input axil_regs_pkg::data_t data, input axil_regs_pkg::strb_t strb);
        s_axil_awaddr = addr;
        s_axil_wdata = data;
        s_axil_wstrb = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid = 1'b1;
        update_model(addr, data, strb);
        wr_issued++;
        while (!(s_axil_awready && s_axil_wready)) @(negedge clk);
        @(negedge clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
    endtask

    // read expectation is taken before the write lands, so it sees the old word.
    task automatic issue_both(input axil_regs_pkg::addr_t waddr, input axil_regs_pkg::data_t data,
                              input axil_regs_pkg::strb_t strb, input axil_regs_pkg::addr_t raddr);
        s_axil_araddr = raddr;
        s_axil_arvalid = 1'b1;
        rd_expect[rd_issued[7:0]] = expected_word(raddr);
        rd_issued++;
        s_axil_awaddr = waddr;
        s_axil_wdata = data;
        s_axil_wstrb = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid = 1'b1;
        update_model(waddr, data, strb);
        wr_issued++;
        while (!(s_axil_arready && s_axil_awready && s_axil_wready)) @(negedge clk);
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
    endtask

    task automatic wait_idle();
        while (rd_done != rd_issued || wr_done != wr_issued) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cycle limit and checker watch.
    always @(negedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout: no response");
        end else if (dut.u_check.fail_count != 0) begin
            abort_run("protocol check failed in the checker");
        end
    end

    // R side stalls rready at random when asked.
    initial begin : read_collector
        rd_done = 0;
        s_axil_rready = 1'b0;
        forever begin
            @(negedge clk);
            s_axil_rready = !stall_ready || ($urandom % 3 != 0);
            if (!rst && s_axil_rvalid && s_axil_rready) begin
                assert (rd_done < rd_issued) else abort_run("read response with no read pending");
                check_value("s_axil_rdata", s_axil_rdata, rd_expect[rd_done[7:0]]);
                check_value("s_axil_rresp", axil_regs_pkg::data_t'(s_axil_rresp), '0);
                rd_done++;
            end
        end
    end

    // B side.
    initial begin : write_collector
        wr_done = 0;
        s_axil_bready = 1'b0;
        forever begin
            @(negedge clk);
            s_axil_bready = !stall_ready || ($urandom % 3 != 0);
            if (!rst && s_axil_bvalid && s_axil_bready) begin
                assert (wr_done < wr_issued) else abort_run("write response with no write pending");
                check_value("s_axil_bresp", axil_regs_pkg::data_t'(s_axil_bresp), '0);
                wr_done++;
            end
        end
    end

    initial begin : stimulus
        axil_regs_pkg::addr_t addr;
        void'($urandom(24943));
        rst = 1'b1;
        s_axil_araddr = '0;
        s_axil_arprot = '0;
        s_axil_arvalid = 1'b0;
        s_axil_awaddr = '0;
        s_axil_awprot = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        stall_ready = 1'b0;
        rd_issued = 0;
        wr_issued = 0;
        model[1] = '0;
        model[2] = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // identifier.
        issue_read(`REG_ID_ADDR);
        wait_idle();

        // strobed writes to fast and slow words with read-back.
        for (int i = 0; i < 8; i++) begin
            addr = (i % 2 == 0) ? `REG_SCRATCH_ADDR : `REG_SLOW_ADDR;
            issue_write(addr, axil_regs_pkg::data_t'($urandom), axil_regs_pkg::strb_t'($urandom));
            wait_idle();
            issue_read(`REG_SCRATCH_ADDR);
            issue_read(`REG_SLOW_ADDR);
            wait_idle();
        end

        // unmapped and id accesses change nothing.
        issue_read(8'h0C);
        issue_write(8'h0C, axil_regs_pkg::data_t'($urandom), 4'hF);
        issue_write(`REG_ID_ADDR, axil_regs_pkg::data_t'($urandom), 4'hF);
        wait_idle();
        issue_read(`REG_ID_ADDR);
        issue_read(`REG_SCRATCH_ADDR);
        issue_read(`REG_SLOW_ADDR);
        wait_idle();

        // back to back under ready stalls.
        stall_ready = 1'b1;
        for (int i = 0; i < 12; i++) begin
            addr = axil_regs_pkg::addr_t'(4 + ($urandom % 2) * 4);
            issue_write(addr, axil_regs_pkg::data_t'($urandom), axil_regs_pkg::strb_t'($urandom));
        end
        wait_idle();
        for (int i = 0; i < 16; i++) begin
            issue_read(axil_regs_pkg::addr_t'(($urandom % 4) * 4));
        end
        wait_idle();
        stall_ready = 1'b0;

        // read and write in the same cycle.
        issue_both(`REG_SLOW_ADDR, axil_regs_pkg::data_t'($urandom), 4'hF, `REG_SCRATCH_ADDR);
        wait_idle();
        issue_both(`REG_SCRATCH_ADDR, axil_regs_pkg::data_t'($urandom), 4'hF, `REG_SCRATCH_ADDR);
        wait_idle();
        issue_both(`REG_SLOW_ADDR, axil_regs_pkg::data_t'($urandom), 4'h5, `REG_SLOW_ADDR);
        wait_idle();
        issue_read(`REG_SCRATCH_ADDR);
        issue_read(`REG_SLOW_ADDR);
        wait_idle();

        if (dut.u_check.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run("protocol check failed in the checker");
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/axil_regs_pkg.sv
verilog/reg_bus_if.sv
verilog/axil_reg_if_rd.sv
verilog/axil_reg_if_wr.sv
verilog/reg_bank.sv
verilog/axil_regs_top.sv
testbench/axil_regs_checker.sv
testbench/axil_regs_tb.sv

//--- verilog/axil_reg_if_rd.sv
`default_nettype none

`include "axil_regs_defs.svh"

module axil_reg_if_rd (
    input  wire                        clk,
    input  wire                        rst,
    input  wire axil_regs_pkg::addr_t  s_axil_araddr,
    input  wire [2:0]                  s_axil_arprot,
    input  wire                        s_axil_arvalid,
    output logic                       s_axil_arready,
    output axil_regs_pkg::data_t       s_axil_rdata,
    output logic [1:0]                 s_axil_rresp,
    output logic                       s_axil_rvalid,
    input  wire                        s_axil_rready,
    reg_bus_if.rd_master               reg_bus
);

    // held address and its valid flag.
    axil_regs_pkg::addr_t     addr_q, addr_next;
    logic                     held_q, held_next;
    // held response.
    axil_regs_pkg::data_t     rdata_q, rdata_next;
    logic                     rvalid_q, rvalid_next;
    logic                     en_q, en_next;
    axil_regs_pkg::timeout_t  tmo_q, tmo_next;
    logic                     done;

    // one address slot; arprot is accepted but not decoded.
    assign s_axil_arready = !held_q;
    assign s_axil_rdata = rdata_q;
    assign s_axil_rresp = 2'b00;
    assign s_axil_rvalid = rvalid_q;

    assign reg_bus.rd_addr = addr_q;
    assign reg_bus.rd_en = en_q;

    // access ends on ack, or when the counter has run out.
    assign done = en_q && (reg_bus.rd_ack || tmo_q == '0);

    always_comb begin
        addr_next = addr_q;
        held_next = held_q;
        rdata_next = rdata_q;
        tmo_next = tmo_q;
        // response drops once taken.
        rvalid_next = rvalid_q && !s_axil_rready;

        // capture whatever data is present.
        if (done) begin
            held_next = 1'b0;
            rdata_next = reg_bus.rd_data;
            rvalid_next = 1'b1;
        end

        // slot free, so sample the bus and rearm the counter.
        if (!held_q) begin
            addr_next = s_axil_araddr;
            held_next = s_axil_arvalid;
            tmo_next = axil_regs_pkg::timeout_t'(`REG_TIMEOUT - 1);
        end

        // wait from the bank freezes the countdown.
        if (en_q && !reg_bus.rd_wait && tmo_q != '0) begin
            tmo_next = tmo_q - 1'b1;
        end

        // strobe only while no response is pending.
        en_next = held_next && !rvalid_next;
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_next;
        rdata_q <= rdata_next;
        if (rst) begin
            held_q <= 1'b0;
            rvalid_q <= 1'b0;
            en_q <= 1'b0;
            tmo_q <= '0;
        end else begin
            held_q <= held_next;
            rvalid_q <= rvalid_next;
            en_q <= en_next;
            tmo_q <= tmo_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axil_reg_if_wr.sv
`default_nettype none

`include "axil_regs_defs.svh"

module axil_reg_if_wr (
    input  wire                        clk,
    input  wire                        rst,
    input  wire axil_regs_pkg::addr_t  s_axil_awaddr,
    input  wire [2:0]                  s_axil_awprot,
    input  wire                        s_axil_awvalid,
    output logic                       s_axil_awready,
    input  wire axil_regs_pkg::data_t  s_axil_wdata,
    input  wire axil_regs_pkg::strb_t  s_axil_wstrb,
    input  wire                        s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic [1:0]                 s_axil_bresp,
    output logic                       s_axil_bvalid,
    input  wire                        s_axil_bready,
    reg_bus_if.wr_master               reg_bus
);

    // held address, data and strobes.
    axil_regs_pkg::addr_t     addr_q, addr_next;
    axil_regs_pkg::data_t     data_q, data_next;
    axil_regs_pkg::strb_t     strb_q, strb_next;
    logic                     held_q, held_next;
    logic                     bvalid_q, bvalid_next;
    logic                     en_q, en_next;
    axil_regs_pkg::timeout_t  tmo_q, tmo_next;
    logic                     done;

    // AW and W share one slot; awprot is accepted but not decoded.
    assign s_axil_awready = !held_q;
    assign s_axil_wready = !held_q;
    assign s_axil_bresp = 2'b00;
    assign s_axil_bvalid = bvalid_q;

    assign reg_bus.wr_addr = addr_q;
    assign reg_bus.wr_data = data_q;
    assign reg_bus.wr_strb = strb_q;
    assign reg_bus.wr_en = en_q;

    // ack or timeout ends the access.
    assign done = en_q && (reg_bus.wr_ack || tmo_q == '0);

    always_comb begin
        addr_next = addr_q;
        data_next = data_q;
        strb_next = strb_q;
        held_next = held_q;
        tmo_next = tmo_q;
        // B holds until bready.
        bvalid_next = bvalid_q && !s_axil_bready;

        if (done) begin
            held_next = 1'b0;
            bvalid_next = 1'b1;
        end

        // accept needs address and data in the same cycle.
        if (!held_q) begin
            addr_next = s_axil_awaddr;
            data_next = s_axil_wdata;
            strb_next = s_axil_wstrb;
            held_next = s_axil_awvalid && s_axil_wvalid;
            tmo_next = axil_regs_pkg::timeout_t'(`REG_TIMEOUT - 1);
        end

        // count only cycles the bank does not ask to wait.
        if (en_q && !reg_bus.wr_wait && tmo_q != '0) begin
            tmo_next = tmo_q - 1'b1;
        end

        // next write waits for the previous B to be taken.
        en_next = held_next && !bvalid_next;
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_next;
        data_q <= data_next;
        strb_q <= strb_next;
        if (rst) begin
            held_q <= 1'b0;
            bvalid_q <= 1'b0;
            en_q <= 1'b0;
            tmo_q <= '0;
        end else begin
            held_q <= held_next;
            bvalid_q <= bvalid_next;
            en_q <= en_next;
            tmo_q <= tmo_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axil_regs_defs.svh
`ifndef AXIL_REGS_DEFS_SVH
`define AXIL_REGS_DEFS_SVH

// bus widths.
`define AXIL_DATA_WIDTH 32
`define AXIL_ADDR_WIDTH 8
`define AXIL_STRB_WIDTH 4

// cycles without wait before a channel gives up.
`define REG_TIMEOUT 4

// register map in byte offsets.
`define REG_ID_ADDR 8'h00
`define REG_SCRATCH_ADDR 8'h04
`define REG_SLOW_ADDR 8'h08

`define REG_ID_VALUE 32'h5A1E0001
`define REG_SLOW_WAIT 2

`endif

//--- verilog/axil_regs_pkg.sv
`default_nettype none

`include "axil_regs_defs.svh"

package axil_regs_pkg;

    // byte address on the register side.
    typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;

    // one register word.
    typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;

    // one enable per data byte.
    typedef logic [`AXIL_STRB_WIDTH-1:0] strb_t;

    // counts from REG_TIMEOUT-1 down to zero.
    typedef logic [$clog2(`REG_TIMEOUT)-1:0] timeout_t;

    // slow register sequencing, one machine per side.
    typedef enum logic [1:0] {slow_idle, slow_waiting, slow_acking} slow_state_t;

endpackage

`default_nettype wire

//--- verilog/axil_regs_top.sv
`default_nettype none

module axil_regs_top (
    input  wire                        clk,
    input  wire                        rst,
    // read address and data.
    input  wire axil_regs_pkg::addr_t  s_axil_araddr,
    input  wire [2:0]                  s_axil_arprot,
    input  wire                        s_axil_arvalid,
    output wire                        s_axil_arready,
    output axil_regs_pkg::data_t       s_axil_rdata,
    output wire [1:0]                  s_axil_rresp,
    output wire                        s_axil_rvalid,
    input  wire                        s_axil_rready,
    // write address, data and response.
    input  wire axil_regs_pkg::addr_t  s_axil_awaddr,
    input  wire [2:0]                  s_axil_awprot,
    input  wire                        s_axil_awvalid,
    output wire                        s_axil_awready,
    input  wire axil_regs_pkg::data_t  s_axil_wdata,
    input  wire axil_regs_pkg::strb_t  s_axil_wstrb,
    input  wire                        s_axil_wvalid,
    output wire                        s_axil_wready,
    output wire [1:0]                  s_axil_bresp,
    output wire                        s_axil_bvalid,
    input  wire                        s_axil_bready
);

    // register strobes between channels and bank.
    reg_bus_if reg_bus ();

    axil_reg_if_rd u_rd (
        .clk            (clk),
        .rst            (rst),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arprot  (s_axil_arprot),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .reg_bus        (reg_bus.rd_master)
    );

    axil_reg_if_wr u_wr (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awprot  (s_axil_awprot),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .reg_bus        (reg_bus.wr_master)
    );

    // decode, storage and slow sequencing.
    reg_bank u_bank (
        .clk     (clk),
        .rst     (rst),
        .reg_bus (reg_bus.target)
    );

endmodule

`default_nettype wire

//--- verilog/reg_bank.sv
`default_nettype none

`include "axil_regs_defs.svh"

module reg_bank (
    input  wire       clk,
    input  wire       rst,
    reg_bus_if.target reg_bus
);

    localparam int SLOW_CNT_W = $clog2(`REG_SLOW_WAIT + 1);

    // index 0 is the read side, index 1 the write side.
    logic [1:0] side_en;
    logic [1:0] side_slow;
    logic [1:0] side_wait;
    logic [1:0] side_ack;

    axil_regs_pkg::data_t scratch_q;
    axil_regs_pkg::data_t slow_q;
    logic                 rd_fast;
    logic                 wr_fast;

    // replace only the enabled bytes.
    function automatic axil_regs_pkg::data_t merge_bytes(
        input axil_regs_pkg::data_t old_word,
        input axil_regs_pkg::data_t new_word,
        input axil_regs_pkg::strb_t strb
    );
        axil_regs_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign side_en = {reg_bus.wr_en, reg_bus.rd_en};
    assign side_slow = {reg_bus.wr_addr == `REG_SLOW_ADDR, reg_bus.rd_addr == `REG_SLOW_ADDR};

    // same sequencing for both sides.
    for (genvar s = 0; s < 2; s++) begin : g_side
        axil_regs_pkg::slow_state_t state;
        logic [SLOW_CNT_W-1:0]      cnt;

        always_ff @(posedge clk) begin
            if (rst) begin
                state <= axil_regs_pkg::slow_idle;
                cnt <= '0;
            end else begin
                case (state)
                    axil_regs_pkg::slow_idle: begin
                        // first wait cycle is the entry cycle.
                        if (side_en[s] && side_slow[s]) begin
                            state <= axil_regs_pkg::slow_waiting;
                            cnt <= SLOW_CNT_W'(`REG_SLOW_WAIT - 1);
                        end
                    end
                    axil_regs_pkg::slow_waiting: begin
                        if (cnt <= SLOW_CNT_W'(1)) begin
                            state <= axil_regs_pkg::slow_acking;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    default: state <= axil_regs_pkg::slow_idle;
                endcase
            end
        end

        // wait covers idle entry and waiting; ack is one cycle.
        assign side_wait[s] = side_en[s] && side_slow[s]
                              && state != axil_regs_pkg::slow_acking;
        assign side_ack[s] = side_en[s] && state == axil_regs_pkg::slow_acking;
    end

    // id and fast scratch ack in the same cycle.
    assign rd_fast = reg_bus.rd_en
                     && (reg_bus.rd_addr == `REG_ID_ADDR || reg_bus.rd_addr == `REG_SCRATCH_ADDR);
    assign wr_fast = reg_bus.wr_en
                     && (reg_bus.wr_addr == `REG_ID_ADDR || reg_bus.wr_addr == `REG_SCRATCH_ADDR);

    // unmapped offsets get neither ack nor wait.
    assign reg_bus.rd_ack = rd_fast || side_ack[0];
    assign reg_bus.rd_wait = side_wait[0];
    assign reg_bus.wr_ack = wr_fast || side_ack[1];
    assign reg_bus.wr_wait = side_wait[1];

    // read mux is zero when unmapped.
    always_comb begin
        case (reg_bus.rd_addr)
            `REG_ID_ADDR:      reg_bus.rd_data = `REG_ID_VALUE;
            `REG_SCRATCH_ADDR: reg_bus.rd_data = scratch_q;
            `REG_SLOW_ADDR:    reg_bus.rd_data = slow_q;
            default:           reg_bus.rd_data = '0;
        endcase
    end

    // id writes are acked and dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            scratch_q <= '0;
            slow_q <= '0;
        end else begin
            if (wr_fast && reg_bus.wr_addr == `REG_SCRATCH_ADDR) begin
                scratch_q <= merge_bytes(scratch_q, reg_bus.wr_data, reg_bus.wr_strb);
            end
            // slow word commits on its ack cycle.
            if (side_ack[1]) begin
                slow_q <= merge_bytes(slow_q, reg_bus.wr_data, reg_bus.wr_strb);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_bus_if.sv
`default_nettype none

interface reg_bus_if;

    // read side.
    axil_regs_pkg::addr_t rd_addr;
    logic                 rd_en;
    axil_regs_pkg::data_t rd_data;
    logic                 rd_wait;
    logic                 rd_ack;

    // write side.
    axil_regs_pkg::addr_t wr_addr;
    axil_regs_pkg::data_t wr_data;
    axil_regs_pkg::strb_t wr_strb;
    logic                 wr_en;
    logic                 wr_wait;
    logic                 wr_ack;

    modport rd_master (output rd_addr, rd_en, input rd_data, rd_wait, rd_ack);

    modport wr_master (output wr_addr, wr_data, wr_strb, wr_en, input wr_wait, wr_ack);

    // bank sees both sides.
    modport target (input rd_addr, rd_en, output rd_data, rd_wait, rd_ack,
                    input wr_addr, wr_data, wr_strb, wr_en, output wr_wait, wr_ack);

endinterface

`default_nettype wire
